// ==== src/soc_map_pkg.sv ====
package soc_map_pkg;

    // Bus widths
    localparam int BUS_ADDR_BITS = 32;
    localparam int BUS_DATA_BITS = 32;

    // Byte offset bits inside a 32-bit word
    localparam int WORD_LSB = 2;

    // Boot ROM window, 4 KB
    localparam logic [BUS_ADDR_BITS-1:0] ROM_BASE = 32'h0000_0000;
    localparam int ROM_WORDS = 1024;
    localparam int ROM_INDEX_BITS = $clog2(ROM_WORDS);
    localparam logic [BUS_ADDR_BITS-1:0] ROM_LIMIT = ROM_BASE + (ROM_WORDS << WORD_LSB);
    localparam string ROM_INIT_FILE = "boot_rom.hex";

    // Data RAM window, 8 KB
    localparam logic [BUS_ADDR_BITS-1:0] RAM_BASE = 32'h0000_1000;
    localparam int RAM_WORDS = 2048;
    localparam int RAM_INDEX_BITS = $clog2(RAM_WORDS);
    localparam logic [BUS_ADDR_BITS-1:0] RAM_LIMIT = RAM_BASE + (RAM_WORDS << WORD_LSB);

    // Memory-mapped peripheral registers
    localparam logic [BUS_ADDR_BITS-1:0] UART_ADDR = 32'h8000_0000;
    localparam logic [BUS_ADDR_BITS-1:0] KEY_ADDR  = 32'h8000_0010;
    localparam logic [BUS_ADDR_BITS-1:0] IRQ_ADDR  = 32'h8000_0020;

    // Read value for holes in the map
    localparam logic [BUS_DATA_BITS-1:0] UNMAPPED_DATA = 32'hDEAD_BEEF;

    // Register field positions
    localparam int UART_BUSY_BIT   = 0;
    localparam int KEY_CODE_LSB    = 0;
    localparam int KEY_CODE_BITS   = 8;
    localparam int KEY_RELEASE_BIT = 8;
    localparam int IRQ_FIELD_LSB   = 0;

endpackage

// ==== src/periph_pkg.sv ====
package periph_pkg;

    // 115200 baud from the 50 MHz board clock
    localparam int UART_BIT_CYCLES = 434;
    localparam int UART_TIMER_BITS = $clog2(UART_BIT_CYCLES);

    // Depth of the PS/2 line synchronizers
    localparam int SYNC_STAGES = 2;

    // Prefix byte sent by the keyboard before a release code
    localparam logic [7:0] PS2_BREAK_CODE = 8'hF0;

    // Interrupt vector codes
    localparam int IRQ_VECTOR_BITS = 4;
    localparam logic [IRQ_VECTOR_BITS-1:0] KEY_IRQ_VECTOR = 4'd1;
    localparam logic [IRQ_VECTOR_BITS-1:0] IRQ_NONE       = 4'd0;

    // PS/2 frame receiver
    typedef enum logic [1:0] {
        PS2_IDLE,
        PS2_DATA,
        PS2_PARITY,
        PS2_STOP
    } ps2_state_e;

    // Serial transmitter
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } uart_state_e;

endpackage

// ==== src/ps2_receiver.sv ====
`timescale 1ns/10ps

module ps2_receiver
    import periph_pkg::*;
(
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic       key_valid,
    output logic [7:0] key_code,
    output logic       key_release
);

    logic [SYNC_STAGES-1:0] clk_sync;
    logic [SYNC_STAGES-1:0] dat_sync;
    logic                   clk_prev;
    logic                   clk_fall;
    logic                   dat_bit;
    ps2_state_e             state;
    logic [2:0]             bit_count;
    logic [7:0]             shift_data;
    logic                   parity_ok;
    logic                   pending_release;
    logic                   frame_ok;

    assign clk_fall = clk_prev & ~clk_sync[SYNC_STAGES-1];
    assign dat_bit  = dat_sync[SYNC_STAGES-1];

    // Stop bit high and odd parity over data plus parity bit
    assign frame_ok = clk_fall && (state == PS2_STOP) && dat_bit && parity_ok;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync        <= '1;
            dat_sync        <= '1;
            clk_prev        <= 1'b1;
            state           <= PS2_IDLE;
            bit_count       <= '0;
            pending_release <= 1'b0;
            key_valid       <= 1'b0;
        end else begin
            clk_sync  <= {clk_sync[SYNC_STAGES-2:0], ps2_clk};
            dat_sync  <= {dat_sync[SYNC_STAGES-2:0], ps2_dat};
            clk_prev  <= clk_sync[SYNC_STAGES-1];
            key_valid <= 1'b0;
            if (clk_fall) begin
                case (state)
                    PS2_IDLE: begin
                        // Start bit is a low data line
                        if (!dat_bit) begin
                            state     <= PS2_DATA;
                            bit_count <= '0;
                        end
                    end
                    PS2_DATA: begin
                        bit_count <= bit_count + 3'd1;
                        if (bit_count == 3'd7) begin
                            state <= PS2_PARITY;
                        end
                    end
                    PS2_PARITY: begin
                        state <= PS2_STOP;
                    end
                    PS2_STOP: begin
                        state <= PS2_IDLE;
                        if (frame_ok) begin
                            if (shift_data == PS2_BREAK_CODE) begin
                                pending_release <= 1'b1;
                            end else begin
                                key_valid       <= 1'b1;
                                pending_release <= 1'b0;
                            end
                        end
                    end
                    default: state <= PS2_IDLE;
                endcase
            end
        end
    end

    // Frame payload, LSB arrives first
    always_ff @(posedge CLOCK_50) begin
        if (clk_fall && state == PS2_DATA) begin
            shift_data <= {dat_bit, shift_data[7:1]};
        end
        if (clk_fall && state == PS2_PARITY) begin
            parity_ok <= ^{shift_data, dat_bit};
        end
        if (frame_ok && shift_data != PS2_BREAK_CODE) begin
            key_code    <= shift_data;
            key_release <= pending_release;
        end
    end

endmodule

// ==== src/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx
    import periph_pkg::*;
(
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       tx_valid,
    input  logic [7:0] tx_data,
    output logic       tx_ready,
    output logic       txd
);

    uart_state_e                state;
    logic [UART_TIMER_BITS-1:0] bit_timer;
    logic [2:0]                 bit_index;
    logic [7:0]                 tx_byte;
    logic                       bit_done;

    assign tx_ready = (state == TX_IDLE);
    assign bit_done = (bit_timer == UART_TIMER_BITS'(UART_BIT_CYCLES - 1));

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state     <= TX_IDLE;
            bit_timer <= '0;
            bit_index <= '0;
            txd       <= 1'b1;
        end else begin
            bit_timer <= bit_done ? '0 : bit_timer + 1'b1;
            case (state)
                TX_IDLE: begin
                    bit_timer <= '0;
                    if (tx_valid) begin
                        state <= TX_START;
                        txd   <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        state     <= TX_DATA;
                        bit_index <= '0;
                        txd       <= tx_byte[0];
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        bit_index <= bit_index + 3'd1;
                        if (bit_index == 3'd7) begin
                            state <= TX_STOP;
                            txd   <= 1'b1;
                        end else begin
                            txd <= tx_byte[bit_index + 3'd1];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_done) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Byte captured at acceptance
    always_ff @(posedge CLOCK_50) begin
        if (tx_valid && tx_ready) begin
            tx_byte <= tx_data;
        end
    end

endmodule

// ==== src/system_bus.sv ====
`timescale 1ns/10ps

module system_bus
    import soc_map_pkg::*, periph_pkg::*;
(
    input  logic                       CLOCK_50,
    input  logic                       KEY0,
    input  logic                       bus_valid,
    input  logic                       bus_write,
    input  logic [BUS_ADDR_BITS-1:0]   bus_address,
    input  logic [BUS_DATA_BITS-1:0]   bus_write_data,
    output logic                       bus_ready,
    output logic [BUS_DATA_BITS-1:0]   bus_read_data,
    output logic                       bus_read_valid,
    input  logic                       key_valid,
    input  logic [7:0]                 key_code,
    input  logic                       key_release,
    output logic                       tx_valid,
    output logic [7:0]                 tx_data,
    input  logic                       tx_ready,
    output logic [IRQ_VECTOR_BITS-1:0] irq_vector
);

    logic [BUS_DATA_BITS-1:0] rom [0:ROM_WORDS-1];
    logic [BUS_DATA_BITS-1:0] ram [0:RAM_WORDS-1];

    initial begin
        $readmemh(ROM_INIT_FILE, rom);
    end

    logic                      rom_sel;
    logic                      ram_sel;
    logic                      uart_sel;
    logic                      key_sel;
    logic                      irq_sel;
    logic [BUS_ADDR_BITS-1:0]  rom_offset;
    logic [BUS_ADDR_BITS-1:0]  ram_offset;
    logic [ROM_INDEX_BITS-1:0] rom_index;
    logic [RAM_INDEX_BITS-1:0] ram_index;
    logic                      accept;
    logic                      read_accept;
    logic                      write_accept;
    logic                      irq_clear;
    logic [7:0]                key_code_q;
    logic                      key_release_q;
    logic [BUS_DATA_BITS-1:0]  uart_word;
    logic [BUS_DATA_BITS-1:0]  key_word;
    logic [BUS_DATA_BITS-1:0]  irq_word;

    // Address decode
    assign rom_sel  = (bus_address >= ROM_BASE) && (bus_address < ROM_LIMIT);
    assign ram_sel  = (bus_address >= RAM_BASE) && (bus_address < RAM_LIMIT);
    assign uart_sel = (bus_address == UART_ADDR);
    assign key_sel  = (bus_address == KEY_ADDR);
    assign irq_sel  = (bus_address == IRQ_ADDR);

    assign rom_offset = bus_address - ROM_BASE;
    assign ram_offset = bus_address - RAM_BASE;
    assign rom_index  = rom_offset[WORD_LSB +: ROM_INDEX_BITS];
    assign ram_index  = ram_offset[WORD_LSB +: RAM_INDEX_BITS];

    // A UART write waits until the transmitter is idle
    assign bus_ready    = !(bus_valid && bus_write && uart_sel && !tx_ready);
    assign accept       = bus_valid && bus_ready;
    assign read_accept  = accept && !bus_write;
    assign write_accept = accept && bus_write;
    assign irq_clear    = write_accept && irq_sel;

    assign tx_valid = write_accept && uart_sel;
    assign tx_data  = bus_write_data[7:0];

    // Peripheral register views
    always_comb begin
        uart_word = '0;
        key_word  = '0;
        irq_word  = '0;
        uart_word[UART_BUSY_BIT] = ~tx_ready;
        key_word[KEY_CODE_LSB +: KEY_CODE_BITS] = key_code_q;
        key_word[KEY_RELEASE_BIT] = key_release_q;
        irq_word[IRQ_FIELD_LSB +: IRQ_VECTOR_BITS] = irq_vector;
    end

    // Memories and registered read data
    always_ff @(posedge CLOCK_50) begin
        if (write_accept && ram_sel) begin
            ram[ram_index] <= bus_write_data;
        end
        if (read_accept) begin
            if (rom_sel) begin
                bus_read_data <= rom[rom_index];
            end else if (ram_sel) begin
                bus_read_data <= ram[ram_index];
            end else if (uart_sel) begin
                bus_read_data <= uart_word;
            end else if (key_sel) begin
                bus_read_data <= key_word;
            end else if (irq_sel) begin
                bus_read_data <= irq_word;
            end else begin
                bus_read_data <= UNMAPPED_DATA;
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_valid <= 1'b0;
            key_code_q     <= '0;
            key_release_q  <= 1'b0;
            irq_vector     <= IRQ_NONE;
        end else begin
            bus_read_valid <= read_accept;
            if (key_valid) begin
                key_code_q    <= key_code;
                key_release_q <= key_release;
            end
            if (irq_clear) begin
                irq_vector <= IRQ_NONE;
            end
            // Make code wins over a clear in the same cycle
            if (key_valid && !key_release) begin
                irq_vector <= KEY_IRQ_VECTOR;
            end
        end
    end

endmodule

// ==== src/soc_top.sv ====
`timescale 1ns/10ps

module soc_top (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic        PS2_CLK,
    input  logic        PS2_DAT,
    output logic        UART_TXD,
    output logic [3:0]  IRQ_VECTOR,
    input  logic        bus_valid,
    input  logic        bus_write,
    input  logic [31:0] bus_address,
    input  logic [31:0] bus_write_data,
    output logic        bus_ready,
    output logic [31:0] bus_read_data,
    output logic        bus_read_valid
);

    logic       key_valid;
    logic [7:0] key_code;
    logic       key_release;
    logic       tx_valid;
    logic [7:0] tx_data;
    logic       tx_ready;

    // Keyboard
    ps2_receiver u_ps2_receiver (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .ps2_clk     (PS2_CLK),
        .ps2_dat     (PS2_DAT),
        .key_valid   (key_valid),
        .key_code    (key_code),
        .key_release (key_release)
    );

    // Serial console
    uart_tx u_uart_tx (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .tx_valid (tx_valid),
        .tx_data  (tx_data),
        .tx_ready (tx_ready),
        .txd      (UART_TXD)
    );

    system_bus u_system_bus (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .bus_valid      (bus_valid),
        .bus_write      (bus_write),
        .bus_address    (bus_address),
        .bus_write_data (bus_write_data),
        .bus_ready      (bus_ready),
        .bus_read_data  (bus_read_data),
        .bus_read_valid (bus_read_valid),
        .key_valid      (key_valid),
        .key_code       (key_code),
        .key_release    (key_release),
        .tx_valid       (tx_valid),
        .tx_data        (tx_data),
        .tx_ready       (tx_ready),
        .irq_vector     (IRQ_VECTOR)
    );

endmodule

// ==== testbench/soc_checker.sv ====
`timescale 1ns/10ps

module soc_checker
    import soc_map_pkg::*;
(
    input logic                     CLOCK_50,
    input logic                     KEY0,
    input logic                     bus_valid,
    input logic                     bus_write,
    input logic [BUS_ADDR_BITS-1:0] bus_address,
    input logic                     bus_ready,
    input logic                     bus_read_valid,
    input logic                     tx_valid,
    input logic                     tx_ready
);

    int unsigned read_failures  = 0;
    int unsigned ready_failures = 0;
    int unsigned tx_failures    = 0;
    int unsigned failures;
    logic        read_accept;

    assign read_accept = bus_valid && bus_ready && !bus_write;
    assign failures    = read_failures + ready_failures + tx_failures;

    // Read response exactly one cycle after each accepted read
    read_response: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_read_valid == $past(read_accept))
    else begin
        $error("bus_read_valid does not follow an accepted read by one cycle");
        read_failures++;
    end

    // A stall needs a UART write to a busy transmitter and keeps that write on the bus
    ready_gating: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !bus_ready |-> (bus_valid && bus_write && bus_address == UART_ADDR && !tx_ready)
                       ##1 (bus_valid && bus_write && bus_address == UART_ADDR))
    else begin
        $error("bus_ready low without a pending UART write to a busy transmitter");
        ready_failures++;
    end

    // Transmitter is idle when it takes a byte and busy in the next cycle
    tx_handshake: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        tx_valid |-> tx_ready ##1 !tx_ready)
    else begin
        $error("tx_valid raised while tx_ready is low or the byte was not taken");
        tx_failures++;
    end

endmodule

bind system_bus soc_checker u_soc_checker (.*);

// ==== testbench/soc_tb.sv ====
`timescale 1ns/10ps

module soc_tb
    import soc_map_pkg::*, periph_pkg::*;
();

    localparam int KIND_READ       = 0;
    localparam int KIND_WRITE      = 1;
    localparam int KIND_KEY        = 2;
    localparam int KIND_SERIAL     = 3;
    localparam int MAX_ROWS        = 64;
    localparam int RESET_CYCLES    = 4;
    localparam int PS2_HALF_CYCLES = 40;
    localparam int BUS_COST        = 20;
    localparam int KEY_COST        = 1000;
    localparam int SERIAL_COST     = 10 * UART_BIT_CYCLES + 100;
    localparam int RAM_QUARTER     = RAM_WORDS / 4;
    localparam logic [31:0] LCG_SEED = 32'd56528;

    logic        CLOCK_50;
    logic        KEY0;
    logic        PS2_CLK;
    logic        PS2_DAT;
    logic        UART_TXD;
    logic [3:0]  IRQ_VECTOR;
    logic        bus_valid;
    logic        bus_write;
    logic [31:0] bus_address;
    logic [31:0] bus_write_data;
    logic        bus_ready;
    logic [31:0] bus_read_data;
    logic        bus_read_valid;

    // Stimulus table, one row per step
    int          row_kind   [0:MAX_ROWS-1];
    logic [31:0] row_addr   [0:MAX_ROWS-1];
    logic [31:0] row_data   [0:MAX_ROWS-1];
    logic        row_bad    [0:MAX_ROWS-1];
    logic [31:0] row_expect [0:MAX_ROWS-1];
    int          row_count = 0;

    logic [7:0]  serial_bytes [$];
    logic [31:0] lcg_state;
    int          cycle_count = 0;
    int          timeout_limit;

    soc_top DUT (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .PS2_CLK        (PS2_CLK),
        .PS2_DAT        (PS2_DAT),
        .UART_TXD       (UART_TXD),
        .IRQ_VECTOR     (IRQ_VECTOR),
        .bus_valid      (bus_valid),
        .bus_write      (bus_write),
        .bus_address    (bus_address),
        .bus_write_data (bus_write_data),
        .bus_ready      (bus_ready),
        .bus_read_data  (bus_read_data),
        .bus_read_valid (bus_read_valid)
    );

    always #10 CLOCK_50 = ~CLOCK_50;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "Run stopped after an error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("FAIL %s: actual 0x%08h, expected 0x%08h",
                               name, actual, expected));
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int row_cost(input int kind);
        case (kind)
            KIND_KEY:    return KEY_COST;
            KIND_SERIAL: return SERIAL_COST;
            default:     return BUS_COST;
        endcase
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge CLOCK_50);
    endtask

    task automatic add_row(input int kind, input logic [31:0] addr, input logic [31:0] data,
                           input logic bad, input logic [31:0] expected);
        row_kind[row_count]   = kind;
        row_addr[row_count]   = addr;
        row_data[row_count]   = data;
        row_bad[row_count]    = bad;
        row_expect[row_count] = expected;
        row_count++;
    endtask

    task automatic build_table();
        logic [31:0] ram_addr [0:3];
        logic [31:0] ram_data [0:3];
        // Boot image words, same as boot_rom.hex
        add_row(KIND_READ, ROM_BASE + 32'h00, 0, 0, 32'h0000_1137);
        add_row(KIND_READ, ROM_BASE + 32'h04, 0, 0, 32'h0001_0113);
        add_row(KIND_READ, ROM_BASE + 32'h08, 0, 0, 32'h0000_0093);
        add_row(KIND_READ, ROM_BASE + 32'h0C, 0, 0, 32'h0010_0193);
        add_row(KIND_READ, ROM_BASE + 32'h10, 0, 0, 32'h0020_0213);
        add_row(KIND_READ, ROM_BASE + 32'h14, 0, 0, 32'h0030_0293);
        add_row(KIND_READ, ROM_BASE + 32'h18, 0, 0, 32'h0040_0313);
        add_row(KIND_READ, ROM_BASE + 32'h1C, 0, 0, 32'h8000_03B7);
        add_row(KIND_READ, ROM_BASE + 32'h20, 0, 0, 32'h0480_0413);
        add_row(KIND_READ, ROM_BASE + 32'h24, 0, 0, 32'h0083_A023);
        add_row(KIND_READ, ROM_BASE + 32'h28, 0, 0, 32'h0690_0493);
        add_row(KIND_READ, ROM_BASE + 32'h2C, 0, 0, 32'h0093_A023);
        add_row(KIND_READ, ROM_BASE + 32'h30, 0, 0, 32'h0000_006F);
        add_row(KIND_READ, ROM_BASE + 32'h34, 0, 0, 32'h0000_0013);
        add_row(KIND_READ, ROM_BASE + 32'h38, 0, 0, 32'h1357_9BDF);
        add_row(KIND_READ, ROM_BASE + 32'h3C, 0, 0, 32'h2468_ACE0);
        add_row(KIND_WRITE, ROM_BASE + 32'h08, 32'hFFFF_FFFF, 0, 0);
        add_row(KIND_READ, ROM_BASE + 32'h08, 0, 0, 32'h0000_0093);
        // One random word per RAM quarter so the addresses never collide
        lcg_state = LCG_SEED;
        for (int k = 0; k < 4; k++) begin
            lcg_state = lcg_next(lcg_state);
            ram_addr[k] = RAM_BASE + ((lcg_state >> 16) % RAM_QUARTER + k * RAM_QUARTER) * 4;
            lcg_state = lcg_next(lcg_state);
            ram_data[k] = lcg_state;
            add_row(KIND_WRITE, ram_addr[k], ram_data[k], 0, 0);
        end
        for (int k = 0; k < 4; k++) begin
            add_row(KIND_READ, ram_addr[k], 0, 0, ram_data[k]);
        end
        add_row(KIND_WRITE, 32'h4000_0000, 32'h0000_0001, 0, 0);
        add_row(KIND_READ, 32'h4000_0000, 0, 0, UNMAPPED_DATA);
        // Second UART write must stall behind the first byte
        add_row(KIND_WRITE, UART_ADDR, 32'h0000_0041, 0, 0);
        add_row(KIND_WRITE, UART_ADDR, 32'h0000_00A5, 0, 1);
        add_row(KIND_READ, UART_ADDR, 0, 0, 32'h1);
        add_row(KIND_SERIAL, 0, 0, 0, 32'h41);
        add_row(KIND_SERIAL, 0, 0, 0, 32'hA5);
        add_row(KIND_READ, UART_ADDR, 0, 0, 32'h0);
        // Keyboard rows, expected value is IRQ_VECTOR after the frame
        add_row(KIND_KEY, 32'h1C, 0, 0, KEY_IRQ_VECTOR);
        add_row(KIND_READ, KEY_ADDR, 0, 0, 32'h0000_001C);
        add_row(KIND_WRITE, IRQ_ADDR, 0, 0, 0);
        add_row(KIND_READ, IRQ_ADDR, 0, 0, IRQ_NONE);
        add_row(KIND_KEY, PS2_BREAK_CODE, 0, 0, IRQ_NONE);
        add_row(KIND_KEY, 32'h1C, 0, 0, IRQ_NONE);
        add_row(KIND_READ, KEY_ADDR, 0, 0, 32'h0000_011C);
        add_row(KIND_KEY, 32'h29, 0, 0, KEY_IRQ_VECTOR);
        add_row(KIND_WRITE, IRQ_ADDR, 0, 0, 0);
        add_row(KIND_READ, IRQ_ADDR, 0, 0, IRQ_NONE);
        add_row(KIND_KEY, 32'h33, 0, 1, IRQ_NONE);
        add_row(KIND_READ, KEY_ADDR, 0, 0, 32'h0000_0029);
    endtask

    task automatic write_bus(input logic [31:0] addr, input logic [31:0] data,
                             output int stalls);
        stalls = 0;
        @(posedge CLOCK_50);
        bus_valid      <= 1'b1;
        bus_write      <= 1'b1;
        bus_address    <= addr;
        bus_write_data <= data;
        @(negedge CLOCK_50);
        while (!bus_ready) begin
            stalls++;
            @(negedge CLOCK_50);
        end
        @(posedge CLOCK_50);
        bus_valid <= 1'b0;
        bus_write <= 1'b0;
    endtask

    task automatic read_bus(input logic [31:0] addr, output logic [31:0] data);
        @(posedge CLOCK_50);
        bus_valid   <= 1'b1;
        bus_write   <= 1'b0;
        bus_address <= addr;
        @(negedge CLOCK_50);
        while (!bus_ready) begin
            @(negedge CLOCK_50);
        end
        @(posedge CLOCK_50);
        bus_valid <= 1'b0;
        @(negedge CLOCK_50);
        while (!bus_read_valid) begin
            @(negedge CLOCK_50);
        end
        data = bus_read_data;
    endtask

    // Keyboard side of the PS/2 link, data changes while the clock is high
    task automatic send_key_frame(input logic [7:0] code, input logic bad_parity);
        logic [10:0] frame;
        frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        @(posedge CLOCK_50);
        for (int i = 0; i < 11; i++) begin
            PS2_DAT <= frame[i];
            wait_cycles(PS2_HALF_CYCLES);
            PS2_CLK <= 1'b0;
            wait_cycles(PS2_HALF_CYCLES);
            PS2_CLK <= 1'b1;
        end
        PS2_DAT <= 1'b1;
        wait_cycles(PS2_HALF_CYCLES);
    endtask

    // Serial receiver, samples each bit at its middle
    initial begin : serial_model
        logic [7:0] rx_byte;
        forever begin
            @(negedge CLOCK_50);
            if (KEY0 === 1'b1 && UART_TXD === 1'b0) begin
                repeat (UART_BIT_CYCLES / 2) @(negedge CLOCK_50);
                if (UART_TXD !== 1'b0) begin
                    fail_run("Serial start bit ended before the middle of the bit");
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (UART_BIT_CYCLES) @(negedge CLOCK_50);
                    rx_byte[i] = UART_TXD;
                end
                repeat (UART_BIT_CYCLES) @(negedge CLOCK_50);
                if (UART_TXD !== 1'b1) begin
                    fail_run("Serial stop bit was not high");
                end
                serial_bytes.push_back(rx_byte);
            end
        end
    end

    always @(posedge CLOCK_50) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            fail_run($sformatf("Timeout: the tests did not finish within %0d cycles",
                               timeout_limit));
        end
    end

    always @(negedge CLOCK_50) begin
        if (DUT.u_system_bus.u_soc_checker.failures != 0) begin
            fail_run("A bus protocol assertion failed");
        end
    end

    initial begin : stimulus
        logic [31:0] read_data;
        logic [7:0]  rx_byte;
        int          stalls;
        CLOCK_50       = 1'b0;
        KEY0           = 1'b0;
        PS2_CLK        = 1'b1;
        PS2_DAT        = 1'b1;
        bus_valid      = 1'b0;
        bus_write      = 1'b0;
        bus_address    = '0;
        bus_write_data = '0;
        build_table();
        timeout_limit = RESET_CYCLES;
        for (int r = 0; r < row_count; r++) begin
            timeout_limit += row_cost(row_kind[r]);
        end
        timeout_limit = 2 * timeout_limit;
        wait_cycles(RESET_CYCLES);
        KEY0 <= 1'b1;
        for (int r = 0; r < row_count; r++) begin
            case (row_kind[r])
                KIND_READ: begin
                    read_bus(row_addr[r], read_data);
                    check_value($sformatf("bus_read_data at 0x%08h", row_addr[r]),
                                read_data, row_expect[r]);
                end
                KIND_WRITE: begin
                    write_bus(row_addr[r], row_data[r], stalls);
                    check_value("bus_ready held low", stalls != 0, row_expect[r]);
                end
                KIND_KEY: begin
                    send_key_frame(row_addr[r][7:0], row_bad[r]);
                    @(negedge CLOCK_50);
                    check_value("IRQ_VECTOR", IRQ_VECTOR, row_expect[r]);
                end
                default: begin
                    while (serial_bytes.size() == 0) begin
                        @(negedge CLOCK_50);
                    end
                    rx_byte = serial_bytes.pop_front();
                    check_value("UART_TXD byte", rx_byte, row_expect[r]);
                    // Rest of the stop bit
                    wait_cycles(UART_BIT_CYCLES / 2 + 2);
                end
            endcase
        end
        wait_cycles(4);
        if (DUT.u_system_bus.u_soc_checker.failures == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            fail_run("A bus protocol assertion failed");
        end
    end

endmodule

// ==== boot_rom.hex ====
// Boot ROM image: one 32-bit word per line, in hex, from word address 0
00001137
00010113
00000093
00100193
00200213
00300293
00400313
800003b7
04800413
0083a023
06900493
0093a023
0000006f
00000013
13579bdf
2468ace0

// ==== flist.f ====
src/soc_map_pkg.sv
src/periph_pkg.sv
src/ps2_receiver.sv
src/uart_tx.sv
src/system_bus.sv
src/soc_top.sv
testbench/soc_checker.sv
testbench/soc_tb.sv

// ==== Bender.yml ====
package:
  name: soc_periph

sources:
  - files:
      - src/soc_map_pkg.sv
      - src/periph_pkg.sv
      - src/ps2_receiver.sv
      - src/uart_tx.sv
      - src/system_bus.sv
      - src/soc_top.sv
  - target: test
    files:
      - testbench/soc_checker.sv
      - testbench/soc_tb.sv
